//--- hdl/pkt_fmt_pkg.sv
package pkt_fmt_pkg;

	//////////////////////////////
	// Header byte layout
	//////////////////////////////

	// Type in the upper nibble, payload length in the lower nibble
	typedef struct packed {
		logic [3:0] pkt_type;
		logic [3:0] byte_cnt;
	} pkt_hdr_fields_t;

	// Same header byte, seen raw on the memory side or split into fields
	typedef union packed {
		logic [7:0]      raw;
		pkt_hdr_fields_t f;
	} pkt_hdr_t;

	// Longest payload that the 4-bit count can describe
	localparam int unsigned MAX_PAYLOAD = 15;

	//////////////////////////////
	// CRC-8
	//////////////////////////////

	// x^8 + x^2 + x + 1
	localparam logic [7:0] CRC8_POLY = 8'h07;
	localparam logic [7:0] CRC8_INIT = 8'h00;

	// Fold one byte into the running CRC, MSB first, no final XOR
	function automatic logic [7:0] crc8_step(input logic [7:0] crc_in, input logic [7:0] data);
		logic [7:0] crc;
		crc = crc_in ^ data;
		for (int i = 0; i < 8; i++) begin
			// Shift out the top bit and reduce when it was set
			if (crc[7]) begin
				crc = {crc[6:0], 1'b0} ^ CRC8_POLY;
			end else begin
				crc = {crc[6:0], 1'b0};
			end
		end
		return crc;
	endfunction

endpackage

//--- hdl/pkt_bus_pkg.sv
package pkt_bus_pkg;

	//////////////////////////////
	// APB slave port
	//////////////////////////////

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic [31:0] prdata;
		logic        pslverr;
	} apb_rsp_t;

	// Register map
	localparam logic [11:0] REG_CTRL      = 12'h000;
	localparam logic [11:0] REG_BUILD_CFG = 12'h004;
	localparam logic [11:0] REG_PARSE_CFG = 12'h008;
	localparam logic [11:0] REG_STATUS    = 12'h00C;
	// One memory byte per 32-bit word from here on
	localparam logic [11:0] MEM_WIN_BASE  = 12'h100;

	//////////////////////////////
	// Task configuration and result
	//////////////////////////////

	typedef struct packed {
		logic [5:0] addr_in;
		logic [5:0] addr_out;
		logic [3:0] byte_cnt;
		logic [3:0] pkt_type;
		logic       crc_en;
	} build_cfg_t;

	typedef struct packed {
		logic [5:0] addr_hdr;
		logic       crc_chk;
	} parse_cfg_t;

	typedef struct packed {
		logic [3:0] pkt_type;
		logic [3:0] byte_cnt;
		logic       crc_err;
	} parse_res_t;

	// Shared memory request, held until granted
	typedef struct packed {
		logic       req;
		logic       we;
		logic [5:0] addr;
		logic [7:0] wdata;
	} mem_req_t;

endpackage

//--- hdl/pkt_regs.sv
module pkt_regs import pkt_bus_pkg::*; #(
	parameter int MEM_DEPTH = 64
) (
	input  logic       clk,
	input  logic       rst_n_i,
	input  apb_req_t   apb_i,
	output apb_rsp_t   apb_o,
	output build_cfg_t build_cfg_o,
	output logic       build_start_o,
	input  logic       build_busy_i,
	input  logic       build_done_i,
	output parse_cfg_t parse_cfg_o,
	output logic       parse_start_o,
	input  logic       parse_busy_i,
	input  logic       parse_done_i,
	input  parse_res_t parse_res_i,
	output mem_req_t   mem_req_o,
	input  logic       mem_gnt_i,
	input  logic [7:0] mem_rdata_i,
	output logic       irq_o
);

	logic        access;
	logic        reg_wr;
	logic [11:0] win_off;
	logic [9:0]  win_idx;
	logic        win_hit;
	logic        reg_hit;
	logic        win_rd_wait;
	logic        build_done_q;
	logic        parse_done_q;
	parse_res_t  parse_res_q;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	// Access phase of an APB transfer
	assign access = apb_i.psel && apb_i.penable;

	// Window word index, valid only above the base
	assign win_off = apb_i.paddr - MEM_WIN_BASE;
	assign win_idx = win_off[11:2];
	assign win_hit = (apb_i.paddr >= MEM_WIN_BASE) && (win_idx < 10'(MEM_DEPTH));

	assign reg_hit = (apb_i.paddr == REG_CTRL) || (apb_i.paddr == REG_BUILD_CFG) ||
		(apb_i.paddr == REG_PARSE_CFG) || (apb_i.paddr == REG_STATUS);

	// Register writes finish in their first access cycle
	assign reg_wr = access && apb_i.pwrite && reg_hit;

	//////////////////////////////
	// Memory window requester
	//////////////////////////////

	// Request stays up until grant, then drops while read data returns
	always_comb begin
		mem_req_o       = '0;
		mem_req_o.req   = access && win_hit && !win_rd_wait;
		mem_req_o.we    = apb_i.pwrite;
		mem_req_o.addr  = win_off[7:2];
		mem_req_o.wdata = apb_i.pwdata[7:0];
	end

	// Granted read, data shows up on the next cycle
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			win_rd_wait <= 1'b0;
		end else begin
			win_rd_wait <= mem_req_o.req && mem_gnt_i && !apb_i.pwrite;
		end
	end

	//////////////////////////////
	// Configuration and status
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			build_cfg_o   <= '0;
			parse_cfg_o   <= '0;
			build_start_o <= 1'b0;
			parse_start_o <= 1'b0;
			build_done_q  <= 1'b0;
			parse_done_q  <= 1'b0;
			parse_res_q   <= '0;
		end else begin
			// Start pulses last one cycle
			build_start_o <= reg_wr && (apb_i.paddr == REG_CTRL) && apb_i.pwdata[0];
			parse_start_o <= reg_wr && (apb_i.paddr == REG_CTRL) && apb_i.pwdata[1];
			if (reg_wr && (apb_i.paddr == REG_BUILD_CFG)) begin
				build_cfg_o.addr_in  <= apb_i.pwdata[5:0];
				build_cfg_o.addr_out <= apb_i.pwdata[13:8];
				build_cfg_o.byte_cnt <= apb_i.pwdata[19:16];
				build_cfg_o.pkt_type <= apb_i.pwdata[23:20];
				build_cfg_o.crc_en   <= apb_i.pwdata[24];
			end
			if (reg_wr && (apb_i.paddr == REG_PARSE_CFG)) begin
				parse_cfg_o.addr_hdr <= apb_i.pwdata[5:0];
				parse_cfg_o.crc_chk  <= apb_i.pwdata[8];
			end
			// Write one to clear, a new done in the same cycle wins
			if (reg_wr && (apb_i.paddr == REG_STATUS) && apb_i.pwdata[0]) begin
				build_done_q <= 1'b0;
			end
			if (reg_wr && (apb_i.paddr == REG_STATUS) && apb_i.pwdata[1]) begin
				parse_done_q <= 1'b0;
			end
			if (build_done_i) begin
				build_done_q <= 1'b1;
			end
			if (parse_done_i) begin
				parse_done_q <= 1'b1;
				parse_res_q  <= parse_res_i;
			end
		end
	end

	assign irq_o = build_done_q || parse_done_q;

	//////////////////////////////
	// APB response
	//////////////////////////////

	always_comb begin
		apb_o = '0;
		if (access && win_hit) begin
			// Window waits on the arbiter
			apb_o.pready = apb_i.pwrite ? mem_gnt_i : win_rd_wait;
			apb_o.prdata = {24'h0, mem_rdata_i};
		end else if (access) begin
			apb_o.pready  = 1'b1;
			apb_o.pslverr = !reg_hit;
			case (apb_i.paddr)
				REG_BUILD_CFG: apb_o.prdata = {7'h0, build_cfg_o.crc_en, build_cfg_o.pkt_type,
					build_cfg_o.byte_cnt, 2'b0, build_cfg_o.addr_out, 2'b0, build_cfg_o.addr_in};
				REG_PARSE_CFG: apb_o.prdata = {23'h0, parse_cfg_o.crc_chk, 2'b0,
					parse_cfg_o.addr_hdr};
				REG_STATUS: apb_o.prdata = {18'h0, parse_busy_i, build_busy_i,
					parse_res_q.byte_cnt, parse_res_q.pkt_type, 1'b0, parse_res_q.crc_err,
					parse_done_q, build_done_q};
				// Control is write-only
				default: apb_o.prdata = '0;
			endcase
		end
	end

endmodule

//--- hdl/pkt_shared_mem.sv
module pkt_shared_mem import pkt_bus_pkg::*; #(
	parameter int MEM_DEPTH = 64
) (
	input  logic       clk,
	input  logic       rst_n_i,
	input  mem_req_t   parse_req_i,
	input  mem_req_t   build_req_i,
	input  mem_req_t   win_req_i,
	output logic       parse_gnt_o,
	output logic       build_gnt_o,
	output logic       win_gnt_o,
	output logic [7:0] rdata_o
);

	localparam int AW = $clog2(MEM_DEPTH);

	logic [7:0] mem [MEM_DEPTH];
	mem_req_t   sel_req;

	//////////////////////////////
	// Fixed-priority arbiter
	//////////////////////////////

	// Parser first, then builder, then the APB window
	always_comb begin
		parse_gnt_o = 1'b0;
		build_gnt_o = 1'b0;
		win_gnt_o   = 1'b0;
		sel_req     = '0;
		if (parse_req_i.req) begin
			parse_gnt_o = 1'b1;
			sel_req     = parse_req_i;
		end else if (build_req_i.req) begin
			build_gnt_o = 1'b1;
			sel_req     = build_req_i;
		end else if (win_req_i.req) begin
			win_gnt_o = 1'b1;
			sel_req   = win_req_i;
		end
	end

	//////////////////////////////
	// Byte array
	//////////////////////////////

	// Granted write lands at this edge
	always_ff @(posedge clk) begin
		if (sel_req.req && sel_req.we) begin
			mem[sel_req.addr[AW-1:0]] <= sel_req.wdata;
		end
	end

	// Granted read returns on the next cycle and holds until the next read
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rdata_o <= '0;
		end else if (sel_req.req && !sel_req.we) begin
			rdata_o <= mem[sel_req.addr[AW-1:0]];
		end
	end

endmodule

//--- hdl/pkt_builder.sv
module pkt_builder import pkt_fmt_pkg::*, pkt_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       start_i,
	input  build_cfg_t cfg_i,
	output mem_req_t   mem_req_o,
	input  logic       mem_gnt_i,
	input  logic [7:0] mem_rdata_i,
	output logic       busy_o,
	output logic       done_o
);

	localparam int IDX_W = $clog2(MAX_PAYLOAD + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_HDR_WR,
		S_RD,
		S_RD_WAIT,
		S_WR,
		S_CRC_WR
	} state_t;

	state_t           state_q;
	build_cfg_t       cfg_q;
	logic [IDX_W-1:0] idx_q;
	logic [IDX_W-1:0] idx_nxt;
	logic [7:0]       data_q;
	logic [7:0]       crc_q;
	pkt_hdr_t         hdr;

	// Header assembled from the captured fields, written raw
	always_comb begin
		hdr.f.pkt_type = cfg_q.pkt_type;
		hdr.f.byte_cnt = cfg_q.byte_cnt;
	end

	assign idx_nxt = idx_q + 1'b1;

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= S_IDLE;
			busy_o  <= 1'b0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				S_IDLE: begin
					// Start only counts while idle
					if (start_i) begin
						state_q <= S_HDR_WR;
						busy_o  <= 1'b1;
					end
				end
				S_HDR_WR: begin
					if (mem_gnt_i && (cfg_q.byte_cnt != '0)) begin
						state_q <= S_RD;
					end else if (mem_gnt_i && cfg_q.crc_en) begin
						state_q <= S_CRC_WR;
					end else if (mem_gnt_i) begin
						state_q <= S_IDLE;
						busy_o  <= 1'b0;
						done_o  <= 1'b1;
					end
				end
				S_RD: begin
					if (mem_gnt_i) begin
						state_q <= S_RD_WAIT;
					end
				end
				S_RD_WAIT: state_q <= S_WR;
				S_WR: begin
					// Last payload byte written
					if (mem_gnt_i && (idx_nxt == cfg_q.byte_cnt) && cfg_q.crc_en) begin
						state_q <= S_CRC_WR;
					end else if (mem_gnt_i && (idx_nxt == cfg_q.byte_cnt)) begin
						state_q <= S_IDLE;
						busy_o  <= 1'b0;
						done_o  <= 1'b1;
					end else if (mem_gnt_i) begin
						state_q <= S_RD;
					end
				end
				S_CRC_WR: begin
					if (mem_gnt_i) begin
						state_q <= S_IDLE;
						busy_o  <= 1'b0;
						done_o  <= 1'b1;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	always_ff @(posedge clk) begin
		if ((state_q == S_IDLE) && start_i) begin
			cfg_q <= cfg_i;
			idx_q <= '0;
		end
		// CRC covers the header first
		if ((state_q == S_HDR_WR) && mem_gnt_i) begin
			crc_q <= crc8_step(CRC8_INIT, hdr.raw);
		end
		if (state_q == S_RD_WAIT) begin
			data_q <= mem_rdata_i;
			crc_q  <= crc8_step(crc_q, mem_rdata_i);
		end
		if ((state_q == S_WR) && mem_gnt_i) begin
			idx_q <= idx_nxt;
		end
	end

	// Memory request follows the state
	always_comb begin
		mem_req_o = '0;
		case (state_q)
			S_HDR_WR: begin
				mem_req_o.req   = 1'b1;
				mem_req_o.we    = 1'b1;
				mem_req_o.addr  = cfg_q.addr_out;
				mem_req_o.wdata = hdr.raw;
			end
			S_RD: begin
				mem_req_o.req  = 1'b1;
				mem_req_o.addr = cfg_q.addr_in + 6'(idx_q);
			end
			S_WR: begin
				mem_req_o.req   = 1'b1;
				mem_req_o.we    = 1'b1;
				mem_req_o.addr  = cfg_q.addr_out + 6'd1 + 6'(idx_q);
				mem_req_o.wdata = data_q;
			end
			S_CRC_WR: begin
				mem_req_o.req   = 1'b1;
				mem_req_o.we    = 1'b1;
				mem_req_o.addr  = cfg_q.addr_out + 6'd1 + 6'(cfg_q.byte_cnt);
				mem_req_o.wdata = crc_q;
			end
			default: mem_req_o = '0;
		endcase
	end

endmodule

//--- hdl/pkt_parser.sv
module pkt_parser import pkt_fmt_pkg::*, pkt_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       start_i,
	input  parse_cfg_t cfg_i,
	output mem_req_t   mem_req_o,
	input  logic       mem_gnt_i,
	input  logic [7:0] mem_rdata_i,
	output logic       busy_o,
	output logic       done_o,
	output parse_res_t res_o
);

	localparam int IDX_W = $clog2(MAX_PAYLOAD + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_HDR_RD,
		S_HDR_WAIT,
		S_PL_RD,
		S_PL_WAIT,
		S_CRC_RD,
		S_CRC_WAIT
	} state_t;

	state_t           state_q;
	parse_cfg_t       cfg_q;
	logic [IDX_W-1:0] idx_q;
	logic [IDX_W-1:0] idx_nxt;
	logic [7:0]       crc_q;
	pkt_hdr_t         hdr_rd;

	// Header byte straight off the memory, decoded into fields
	assign hdr_rd.raw = mem_rdata_i;
	assign idx_nxt    = idx_q + 1'b1;

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= S_IDLE;
			busy_o  <= 1'b0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (start_i) begin
						state_q <= S_HDR_RD;
						busy_o  <= 1'b1;
					end
				end
				S_HDR_RD: begin
					if (mem_gnt_i) begin
						state_q <= S_HDR_WAIT;
					end
				end
				S_HDR_WAIT: begin
					// Empty payload goes straight to the CRC or ends
					if (hdr_rd.f.byte_cnt != '0) begin
						state_q <= S_PL_RD;
					end else if (cfg_q.crc_chk) begin
						state_q <= S_CRC_RD;
					end else begin
						state_q <= S_IDLE;
						busy_o  <= 1'b0;
						done_o  <= 1'b1;
					end
				end
				S_PL_RD: begin
					if (mem_gnt_i) begin
						state_q <= S_PL_WAIT;
					end
				end
				S_PL_WAIT: begin
					if (idx_nxt != res_o.byte_cnt) begin
						state_q <= S_PL_RD;
					end else if (cfg_q.crc_chk) begin
						state_q <= S_CRC_RD;
					end else begin
						state_q <= S_IDLE;
						busy_o  <= 1'b0;
						done_o  <= 1'b1;
					end
				end
				S_CRC_RD: begin
					if (mem_gnt_i) begin
						state_q <= S_CRC_WAIT;
					end
				end
				S_CRC_WAIT: begin
					state_q <= S_IDLE;
					busy_o  <= 1'b0;
					done_o  <= 1'b1;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	always_ff @(posedge clk) begin
		if ((state_q == S_IDLE) && start_i) begin
			cfg_q         <= cfg_i;
			idx_q         <= '0;
			// Stays clear unless the stored CRC is checked
			res_o.crc_err <= 1'b0;
		end
		if (state_q == S_HDR_WAIT) begin
			res_o.pkt_type <= hdr_rd.f.pkt_type;
			res_o.byte_cnt <= hdr_rd.f.byte_cnt;
			crc_q          <= crc8_step(CRC8_INIT, hdr_rd.raw);
		end
		if (state_q == S_PL_WAIT) begin
			crc_q <= crc8_step(crc_q, mem_rdata_i);
			idx_q <= idx_nxt;
		end
		if (state_q == S_CRC_WAIT) begin
			res_o.crc_err <= (mem_rdata_i != crc_q);
		end
	end

	// Reads only, payload starts right after the header
	always_comb begin
		mem_req_o = '0;
		case (state_q)
			S_HDR_RD: begin
				mem_req_o.req  = 1'b1;
				mem_req_o.addr = cfg_q.addr_hdr;
			end
			S_PL_RD: begin
				mem_req_o.req  = 1'b1;
				mem_req_o.addr = cfg_q.addr_hdr + 6'd1 + 6'(idx_q);
			end
			S_CRC_RD: begin
				mem_req_o.req  = 1'b1;
				mem_req_o.addr = cfg_q.addr_hdr + 6'd1 + 6'(res_o.byte_cnt);
			end
			default: mem_req_o = '0;
		endcase
	end

endmodule

//--- hdl/pkt_engine_top.sv
module pkt_engine_top import pkt_bus_pkg::*; #(
	parameter int MEM_DEPTH = 64
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  apb_req_t apb_i,
	output apb_rsp_t apb_o,
	output logic     irq_o
);

	build_cfg_t build_cfg;
	parse_cfg_t parse_cfg;
	parse_res_t parse_res;
	logic       build_start;
	logic       build_busy;
	logic       build_done;
	logic       parse_start;
	logic       parse_busy;
	logic       parse_done;

	// Shared memory side, one request and grant per requester
	mem_req_t   win_req;
	mem_req_t   build_req;
	mem_req_t   parse_req;
	logic       win_gnt;
	logic       build_gnt;
	logic       parse_gnt;
	logic [7:0] mem_rdata;

	pkt_regs #(
		.MEM_DEPTH(MEM_DEPTH)
	) pkt_regs_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.apb_i(apb_i),
		.apb_o(apb_o),
		.build_cfg_o(build_cfg),
		.build_start_o(build_start),
		.build_busy_i(build_busy),
		.build_done_i(build_done),
		.parse_cfg_o(parse_cfg),
		.parse_start_o(parse_start),
		.parse_busy_i(parse_busy),
		.parse_done_i(parse_done),
		.parse_res_i(parse_res),
		.mem_req_o(win_req),
		.mem_gnt_i(win_gnt),
		.mem_rdata_i(mem_rdata),
		.irq_o(irq_o)
	);

	pkt_builder pkt_builder_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(build_start),
		.cfg_i(build_cfg),
		.mem_req_o(build_req),
		.mem_gnt_i(build_gnt),
		.mem_rdata_i(mem_rdata),
		.busy_o(build_busy),
		.done_o(build_done)
	);

	pkt_parser pkt_parser_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(parse_start),
		.cfg_i(parse_cfg),
		.mem_req_o(parse_req),
		.mem_gnt_i(parse_gnt),
		.mem_rdata_i(mem_rdata),
		.busy_o(parse_busy),
		.done_o(parse_done),
		.res_o(parse_res)
	);

	pkt_shared_mem #(
		.MEM_DEPTH(MEM_DEPTH)
	) pkt_shared_mem_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.parse_req_i(parse_req),
		.build_req_i(build_req),
		.win_req_i(win_req),
		.parse_gnt_o(parse_gnt),
		.build_gnt_o(build_gnt),
		.win_gnt_o(win_gnt),
		.rdata_o(mem_rdata)
	);

endmodule

//--- verification/pkt_engine_tb.sv
module pkt_engine_tb import pkt_bus_pkg::*;;

	// Byte sequence as used for payloads and whole packets
	typedef logic [7:0] bytes_t[$];

	localparam logic [31:0] LFSR_SEED      = 32'h7cf07e19;
	localparam int          APB_TIMEOUT    = 50;
	localparam int          DONE_POLLS     = 100;
	localparam int          DRAIN_TIMEOUT  = 20;
	// Writable field bits of the two configuration registers
	localparam logic [31:0] BUILD_CFG_MASK = 32'h01FF_3F3F;
	localparam logic [31:0] PARSE_CFG_MASK = 32'h0000_013F;

	logic     clk;
	logic     rst_n_i;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     irq_o;

	logic [31:0] lfsr_q;
	int          chk_cnt;
	int          err_cnt;
	int          test_err_base;

	// Memory compares queued by the tests
	logic [7:0] got_q[$];
	logic [7:0] exp_q[$];
	string      name_q[$];

	pkt_engine_top pkt_engine_top_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.apb_i(apb_req),
		.apb_o(apb_rsp),
		.irq_o(irq_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	//////////////////////////////
	// Random numbers
	//////////////////////////////

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			val    = {val[30:0], lfsr_q[31]};
			lfsr_q = {lfsr_q[30:0], fb};
		end
		return val;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Bit-serial CRC-8 with polynomial 07 and zero start taken MSB first
	function automatic logic [7:0] crc8_ref(input bytes_t data);
		logic [7:0] crc;
		logic       fb;
		crc = 8'h00;
		foreach (data[i]) begin
			for (int b = 7; b >= 0; b--) begin
				fb  = crc[7] ^ data[i][b];
				crc = {crc[6:0], 1'b0};
				if (fb) begin
					crc = crc ^ 8'h07;
				end
			end
		end
		return crc;
	endfunction

	// Header with type high and count low, then payload, then CRC over both
	function automatic bytes_t ref_packet(input logic [3:0] typ, input bytes_t payload,
			input logic crc_en);
		bytes_t pkt;
		pkt.push_back({typ, 4'(payload.size())});
		foreach (payload[i]) begin
			pkt.push_back(payload[i]);
		end
		if (crc_en) begin
			pkt.push_back(crc8_ref(pkt));
		end
		return pkt;
	endfunction

	// What a parse of these bytes should report
	function automatic parse_res_t ref_parse(input bytes_t pkt, input logic crc_chk);
		parse_res_t res;
		bytes_t     covered;
		int         cnt;
		res.pkt_type = pkt[0][7:4];
		res.byte_cnt = pkt[0][3:0];
		cnt          = int'(pkt[0][3:0]);
		for (int i = 0; i <= cnt; i++) begin
			covered.push_back(pkt[i]);
		end
		res.crc_err = crc_chk && (pkt[cnt + 1] != crc8_ref(covered));
		return res;
	endfunction

	function automatic logic [31:0] build_cfg_word(input logic [5:0] addr_in,
			input logic [5:0] addr_out, input logic [3:0] cnt, input logic [3:0] typ,
			input logic crc_en);
		return 32'(addr_in) | (32'(addr_out) << 8) | (32'(cnt) << 16) |
			(32'(typ) << 20) | (32'(crc_en) << 24);
	endfunction

	function automatic logic [31:0] parse_cfg_word(input logic [5:0] addr_hdr,
			input logic crc_chk);
		return 32'(addr_hdr) | (32'(crc_chk) << 8);
	endfunction

	// One memory byte per word in the window
	function automatic logic [11:0] win_addr(input logic [5:0] a);
		return MEM_WIN_BASE + {4'h0, a, 2'b00};
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0t: %s is %08h, expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0t: %s is %02h, expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_res(input string name, input parse_res_t got, input parse_res_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0t: %s is type %h cnt %h err %b, expected type %h cnt %h err %b",
				$time, name, got.pkt_type, got.byte_cnt, got.crc_err,
				exp.pkt_type, exp.byte_cnt, exp.crc_err);
		end
	endtask

	// Compare process for memory bytes read back through the window
	always @(negedge clk) begin
		while ((got_q.size() != 0) && (exp_q.size() != 0)) begin
			check_byte(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
		end
	end

	task automatic drain_compares();
		int cycles;
		cycles = 0;
		while ((got_q.size() != 0) && (cycles < DRAIN_TIMEOUT)) begin
			@(negedge clk);
			cycles++;
		end
		if (got_q.size() != 0) begin
			err_cnt++;
			$display("Compare process left %0d memory bytes unchecked", got_q.size());
		end
	endtask

	task automatic end_test(input int num, input string title);
		drain_compares();
		$display("Test %0d %s: %0d errors", num, title, err_cnt - test_err_base);
		test_err_base = err_cnt;
	endtask

	//////////////////////////////
	// APB driver
	//////////////////////////////

	// Setup then access phase with pready sampled in the middle of the low phase
	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr);
		int   cycles;
		logic ready;
		cycles = 0;
		ready  = 1'b0;
		rdata  = '0;
		slverr = 1'b0;
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		while (!ready && (cycles < APB_TIMEOUT)) begin
			#1;
			ready  = apb_rsp.pready;
			rdata  = apb_rsp.prdata;
			slverr = apb_rsp.pslverr;
			@(negedge clk);
			cycles++;
		end
		apb_req = '0;
		if (!ready) begin
			err_cnt++;
			$display("APB transfer at address %03h never saw pready within %0d cycles",
				addr, APB_TIMEOUT);
		end
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] unused_rd;
		logic        err;
		apb_xfer(1'b1, addr, data, unused_rd, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, 32'h0, data, err);
	endtask

	// Poll the status register until a sticky done bit shows up
	task automatic wait_done_bit(input int bit_idx, input string what);
		logic [31:0] st;
		int          polls;
		st    = '0;
		polls = 0;
		while (!st[bit_idx] && (polls < DONE_POLLS)) begin
			apb_read(REG_STATUS, st);
			polls++;
		end
		if (!st[bit_idx]) begin
			err_cnt++;
			$display("%s never appeared in REG_STATUS after %0d polls", what, DONE_POLLS);
		end
	endtask

	// Read a packet back and hand each byte to the compare process
	task automatic queue_mem_compare(input logic [5:0] base, input bytes_t exp);
		logic [31:0] rd;
		logic [5:0]  a;
		foreach (exp[i]) begin
			a = base + 6'(i);
			apb_read(win_addr(a), rd);
			got_q.push_back(rd[7:0]);
			exp_q.push_back(exp[i]);
			name_q.push_back($sformatf("mem[%0d]", a));
		end
	endtask

	task automatic run_parse(input logic [5:0] addr_hdr, input logic crc_chk,
			output parse_res_t res);
		logic [31:0] st;
		apb_write(REG_PARSE_CFG, parse_cfg_word(addr_hdr, crc_chk));
		apb_write(REG_CTRL, 32'h2);
		wait_done_bit(1, "parse_done");
		apb_read(REG_STATUS, st);
		res.pkt_type = st[7:4];
		res.byte_cnt = st[11:8];
		res.crc_err  = st[2];
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	initial begin : stimulus
		logic [31:0] rd;
		logic [31:0] val;
		logic        err;
		logic [7:0]  data_arr [8];
		logic [5:0]  addr_in;
		logic [5:0]  addr_out;
		logic [5:0]  addr2;
		logic [3:0]  cnt;
		logic [3:0]  typ;
		logic [7:0]  marker;
		bytes_t      payload;
		bytes_t      pkt;
		bytes_t      bad_pkt;
		parse_res_t  res_got;
		int          flip;

		lfsr_q        = LFSR_SEED;
		chk_cnt       = 0;
		err_cnt       = 0;
		test_err_base = 0;
		rst_n_i       = 1'b0;
		apb_req       = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;

		// Test 1 checks reset state and configuration readback
		apb_read(REG_STATUS, rd);
		check_word("REG_STATUS after reset", rd, 32'h0);
		check_flag("irq_o after reset", irq_o, 1'b0);
		apb_read(REG_CTRL, rd);
		check_word("REG_CTRL", rd, 32'h0);
		val = rand_bits(32);
		apb_write(REG_BUILD_CFG, val);
		apb_read(REG_BUILD_CFG, rd);
		check_word("REG_BUILD_CFG", rd, val & BUILD_CFG_MASK);
		val = rand_bits(32);
		apb_write(REG_PARSE_CFG, val);
		apb_read(REG_PARSE_CFG, rd);
		check_word("REG_PARSE_CFG", rd, val & PARSE_CFG_MASK);
		end_test(1, "reset and config readback");

		// Test 2 covers window bytes at the top of memory and unmapped addresses
		for (int i = 0; i < 8; i++) begin
			data_arr[i] = rand_bits(8);
			apb_write(win_addr(6'(56 + i)), 32'(data_arr[i]));
		end
		for (int i = 0; i < 8; i++) begin
			apb_read(win_addr(6'(56 + i)), rd);
			check_byte($sformatf("window mem[%0d]", 56 + i), rd[7:0], data_arr[i]);
		end
		apb_xfer(1'b0, 12'h010, 32'h0, rd, err);
		check_flag("pslverr at 010", err, 1'b1);
		// First word past the end of the window
		apb_xfer(1'b1, win_addr(6'd0) + 12'h100, 32'h5a, rd, err);
		check_flag("pslverr at 200", err, 1'b1);
		end_test(2, "memory window and unmapped address");

		// Test 3 builds with CRC on a random payload
		cnt = rand_bits(4);
		if (cnt == 4'h0) begin
			cnt = 4'h1;
		end
		typ      = rand_bits(4);
		addr_in  = 6'(rand_bits(4));
		addr_out = 6'd32 + 6'(rand_bits(3));
		for (int i = 0; i < int'(cnt); i++) begin
			payload.push_back(rand_bits(8));
			apb_write(win_addr(addr_in + 6'(i)), 32'(payload[i]));
		end
		apb_write(REG_BUILD_CFG, build_cfg_word(addr_in, addr_out, cnt, typ, 1'b1));
		apb_write(REG_CTRL, 32'h1);
		// Shortest build runs longer than this read
		apb_read(REG_STATUS, rd);
		check_flag("build_busy after start", rd[12], 1'b1);
		wait_done_bit(0, "build_done");
		check_flag("irq_o after build", irq_o, 1'b1);
		pkt = ref_packet(typ, payload, 1'b1);
		queue_mem_compare(addr_out, pkt);
		end_test(3, "build with CRC");

		// Test 4 parses the built packet and then clears both done bits
		run_parse(addr_out, 1'b1, res_got);
		check_res("parse result", res_got, ref_parse(pkt, 1'b1));
		apb_write(REG_STATUS, 32'h3);
		check_flag("irq_o after clear", irq_o, 1'b0);
		apb_read(REG_STATUS, rd);
		check_word("REG_STATUS done bits after clear", 32'(rd[1:0]), 32'h0);
		end_test(4, "parse with CRC check");

		// Test 5 corrupts one payload byte and parses with and without the check
		flip    = int'(rand_bits(4)) % int'(cnt);
		bad_pkt = pkt;
		bad_pkt[1 + flip] = bad_pkt[1 + flip] ^ (rand_bits(8) | 8'h01);
		apb_write(win_addr(addr_out + 6'd1 + 6'(flip)), 32'(bad_pkt[1 + flip]));
		run_parse(addr_out, 1'b1, res_got);
		check_res("parse of corrupted packet", res_got, ref_parse(bad_pkt, 1'b1));
		apb_write(REG_STATUS, 32'h2);
		run_parse(addr_out, 1'b0, res_got);
		check_res("parse without CRC check", res_got, ref_parse(bad_pkt, 1'b0));
		apb_write(REG_STATUS, 32'h2);
		end_test(5, "CRC error detection");

		// Test 6 builds without CRC and the byte after the payload must survive
		typ    = rand_bits(4);
		addr2  = 6'd32 + 6'(rand_bits(3));
		marker = rand_bits(8);
		apb_write(win_addr(addr2 + 6'd1 + 6'(cnt)), 32'(marker));
		apb_write(REG_BUILD_CFG, build_cfg_word(addr_in, addr2, cnt, typ, 1'b0));
		apb_write(REG_CTRL, 32'h1);
		wait_done_bit(0, "build_done");
		apb_write(REG_STATUS, 32'h1);
		pkt = ref_packet(typ, payload, 1'b0);
		pkt.push_back(marker);
		queue_mem_compare(addr2, pkt);
		end_test(6, "build without CRC");

		$display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- all.f
hdl/pkt_fmt_pkg.sv
hdl/pkt_bus_pkg.sv
hdl/pkt_regs.sv
hdl/pkt_shared_mem.sv
hdl/pkt_builder.sv
hdl/pkt_parser.sv
hdl/pkt_engine_top.sv
verification/pkt_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the packet engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f --top-module pkt_engine_tb -o pkt_engine_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/pkt_engine_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "No errors" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1
